/* common/isect_pkg.sv */
`default_nettype none

package isect_pkg;

  // Controller states of the rendezvous stage latch.
  typedef enum logic [1:0] {
    idle      = 2'd0, // Neither pulse has arrived.
    free_wait = 2'd1, // Downstream slot free, waiting for upstream done.
    data_wait = 2'd2, // Upstream done, waiting for downstream capture.
    load      = 2'd3  // Data just loaded, capture pulse goes out.
  } latch_state_t;

  // Outcome of one ray/triangle test, in order of precedence.
  typedef enum logic [1:0] {
    res_parallel = 2'd0, // Determinant is zero.
    res_outside  = 2'd1, // Ray passes outside the triangle.
    res_behind   = 2'd2, // Intersection at or behind the origin.
    res_hit      = 2'd3
  } result_t;

endpackage

`default_nettype wire

/* verilog/stage_latch.sv */
`timescale 1ns/100ps
`default_nettype none

module stage_latch #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             done,
  input  logic             next_capture,
  output logic             capture,
  input  logic [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out
);

  isect_pkg::latch_state_t state;
  isect_pkg::latch_state_t next_state;
  logic                    ld;

  // Reset lands in free_wait so an empty pipe takes data at once.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= isect_pkg::free_wait;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      data_out <= '0;
    end else if (ld) begin
      data_out <= data_in;
    end
  end

  always_comb begin
    ld         = 1'b0;
    capture    = 1'b0;
    next_state = isect_pkg::idle;
    case (state)
      isect_pkg::load: begin
        capture    = 1'b1; // Acknowledges upstream and flags valid data downstream.
        next_state = isect_pkg::idle;
      end
      isect_pkg::free_wait: begin
        next_state = isect_pkg::free_wait;
        if (done) begin
          ld         = 1'b1;
          next_state = isect_pkg::load;
        end
      end
      isect_pkg::data_wait: begin
        next_state = isect_pkg::data_wait;
        if (next_capture) begin
          ld         = 1'b1;
          next_state = isect_pkg::load;
        end
      end
      default: begin
        if (done && next_capture) begin
          ld         = 1'b1;
          next_state = isect_pkg::load;
        end else if (next_capture) begin
          next_state = isect_pkg::free_wait;
        end else if (done) begin
          next_state = isect_pkg::data_wait;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/pvec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module pvec_unit #(
  parameter  int COORD_W = 12,
  localparam int CROSS_W = 2 * COORD_W + 2,
  localparam int DOT_W   = 3 * COORD_W + 4
) (
  input  logic signed [COORD_W-1:0] orig_x, orig_y, orig_z,
  input  logic signed [COORD_W-1:0] dir_x, dir_y, dir_z,
  input  logic signed [COORD_W-1:0] v0_x, v0_y, v0_z,
  input  logic signed [COORD_W-1:0] v1_x, v1_y, v1_z,
  input  logic signed [COORD_W-1:0] v2_x, v2_y, v2_z,
  output logic signed [DOT_W-1:0]   det,
  output logic signed [DOT_W-1:0]   u_num
);

  logic signed [COORD_W:0]   e1_x, e1_y, e1_z;
  logic signed [COORD_W:0]   e2_x, e2_y, e2_z;
  logic signed [COORD_W:0]   tvec_x, tvec_y, tvec_z;
  logic signed [CROSS_W-1:0] pvec_x, pvec_y, pvec_z;

  assign e1_x   = v1_x - v0_x;
  assign e1_y   = v1_y - v0_y;
  assign e1_z   = v1_z - v0_z;
  assign e2_x   = v2_x - v0_x;
  assign e2_y   = v2_y - v0_y;
  assign e2_z   = v2_z - v0_z;
  assign tvec_x = orig_x - v0_x;
  assign tvec_y = orig_y - v0_y;
  assign tvec_z = orig_z - v0_z;

  // The p vector is dir cross e2.
  assign pvec_x = dir_y * e2_z - dir_z * e2_y;
  assign pvec_y = dir_z * e2_x - dir_x * e2_z;
  assign pvec_z = dir_x * e2_y - dir_y * e2_x;

  assign det   = e1_x * pvec_x + e1_y * pvec_y + e1_z * pvec_z;
  assign u_num = tvec_x * pvec_x + tvec_y * pvec_y + tvec_z * pvec_z;

endmodule

`default_nettype wire

/* verilog/qvec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module qvec_unit #(
  parameter  int COORD_W = 12,
  localparam int CROSS_W = 2 * COORD_W + 2,
  localparam int DOT_W   = 3 * COORD_W + 4
) (
  input  logic signed [COORD_W-1:0] orig_x, orig_y, orig_z,
  input  logic signed [COORD_W-1:0] dir_x, dir_y, dir_z,
  input  logic signed [COORD_W-1:0] v0_x, v0_y, v0_z,
  input  logic signed [COORD_W-1:0] v1_x, v1_y, v1_z,
  input  logic signed [COORD_W-1:0] v2_x, v2_y, v2_z,
  output logic signed [DOT_W-1:0]   v_num,
  output logic signed [DOT_W-1:0]   t_num
);

  logic signed [COORD_W:0]   e1_x, e1_y, e1_z;
  logic signed [COORD_W:0]   e2_x, e2_y, e2_z;
  logic signed [COORD_W:0]   tvec_x, tvec_y, tvec_z;
  logic signed [CROSS_W-1:0] qvec_x, qvec_y, qvec_z;

  assign tvec_x = orig_x - v0_x;
  assign tvec_y = orig_y - v0_y;
  assign tvec_z = orig_z - v0_z;
  assign e1_x   = v1_x - v0_x;
  assign e1_y   = v1_y - v0_y;
  assign e1_z   = v1_z - v0_z;
  assign e2_x   = v2_x - v0_x;
  assign e2_y   = v2_y - v0_y;
  assign e2_z   = v2_z - v0_z;

  // The q vector is tvec cross e1.
  assign qvec_x = tvec_y * e1_z - tvec_z * e1_y;
  assign qvec_y = tvec_z * e1_x - tvec_x * e1_z;
  assign qvec_z = tvec_x * e1_y - tvec_y * e1_x;

  assign v_num = dir_x * qvec_x + dir_y * qvec_y + dir_z * qvec_z;
  assign t_num = e2_x * qvec_x + e2_y * qvec_y + e2_z * qvec_z;

endmodule

`default_nettype wire

/* verilog/hit_resolve.sv */
`timescale 1ns/100ps
`default_nettype none

module hit_resolve #(
  parameter  int COORD_W = 12,
  localparam int DOT_W   = 3 * COORD_W + 4
) (
  input  logic signed [DOT_W-1:0] det,
  input  logic signed [DOT_W-1:0] u_num,
  input  logic signed [DOT_W-1:0] v_num,
  input  logic signed [DOT_W-1:0] t_num,
  output isect_pkg::result_t      result,
  output logic signed [DOT_W-1:0] det_abs,
  output logic signed [DOT_W-1:0] t_out
);

  logic                   det_neg;
  logic signed [DOT_W-1:0] u_n;
  logic signed [DOT_W-1:0] v_n;
  logic signed [DOT_W:0]   uv_sum;

  assign det_neg = det[DOT_W-1];

  // A back-facing triangle flips every sign so that det_abs ends up non-negative.
  assign det_abs = det_neg ? -det : det;
  assign u_n     = det_neg ? -u_num : u_num;
  assign v_n     = det_neg ? -v_num : v_num;
  assign t_out   = det_neg ? -t_num : t_num;

  assign uv_sum = u_n + v_n; // One extra bit keeps the sum from wrapping.

  always_comb begin
    if (det == '0) begin
      result = isect_pkg::res_parallel;
    end else if (u_n < 0 || v_n < 0 || uv_sum > det_abs) begin
      result = isect_pkg::res_outside;
    end else if (t_out <= 0) begin
      result = isect_pkg::res_behind;
    end else begin
      result = isect_pkg::res_hit;
    end
  end

endmodule

`default_nettype wire

/* verilog/isect_top.sv */
`timescale 1ns/100ps
`default_nettype none

module isect_top #(
  parameter  int COORD_W = 12,
  parameter  int ID_W    = 9,
  localparam int DOT_W   = 3 * COORD_W + 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  output logic                     in_capture,
  input  logic signed [COORD_W-1:0] orig_x, orig_y, orig_z,
  input  logic signed [COORD_W-1:0] dir_x, dir_y, dir_z,
  input  logic signed [COORD_W-1:0] v0_x, v0_y, v0_z,
  input  logic signed [COORD_W-1:0] v1_x, v1_y, v1_z,
  input  logic signed [COORD_W-1:0] v2_x, v2_y, v2_z,
  input  logic [ID_W-1:0]          tri_id,
  output logic                     out_valid,
  input  logic                     out_taken,
  output isect_pkg::result_t       result,
  output logic signed [DOT_W-1:0]  t_num,
  output logic signed [DOT_W-1:0]  det,
  output logic [ID_W-1:0]          out_tri_id
);

  localparam int A_W = 15 * COORD_W + ID_W; // Five vectors plus the id.
  localparam int B_W = 4 * DOT_W + ID_W;
  localparam int C_W = 2 + 2 * DOT_W + ID_W;

  logic [A_W-1:0] a_d, a_q;
  logic [B_W-1:0] b_d, b_q;
  logic [C_W-1:0] c_d, c_q;
  logic           mid_capture;

  logic signed [COORD_W-1:0] a_orig_x, a_orig_y, a_orig_z;
  logic signed [COORD_W-1:0] a_dir_x, a_dir_y, a_dir_z;
  logic signed [COORD_W-1:0] a_v0_x, a_v0_y, a_v0_z;
  logic signed [COORD_W-1:0] a_v1_x, a_v1_y, a_v1_z;
  logic signed [COORD_W-1:0] a_v2_x, a_v2_y, a_v2_z;
  logic [ID_W-1:0]           a_tri_id;
  logic signed [DOT_W-1:0]   det_w, u_num_w, v_num_w, t_num_w;

  logic signed [DOT_W-1:0] b_det, b_u_num, b_v_num, b_t_num;
  logic [ID_W-1:0]         b_tri_id;
  isect_pkg::result_t      res_w;
  logic signed [DOT_W-1:0] det_abs_w, t_out_w;
  logic [1:0]              c_res;

  assign a_d = {tri_id, orig_x, orig_y, orig_z, dir_x, dir_y, dir_z,
                v0_x, v0_y, v0_z, v1_x, v1_y, v1_z, v2_x, v2_y, v2_z};

  stage_latch #(.WIDTH(A_W)) u_latch_in (
    .clk(clk), .rst(rst), .done(in_valid), .next_capture(mid_capture),
    .capture(in_capture), .data_in(a_d), .data_out(a_q)
  );

  assign {a_tri_id, a_orig_x, a_orig_y, a_orig_z, a_dir_x, a_dir_y, a_dir_z,
          a_v0_x, a_v0_y, a_v0_z, a_v1_x, a_v1_y, a_v1_z,
          a_v2_x, a_v2_y, a_v2_z} = a_q;

  pvec_unit #(.COORD_W(COORD_W)) u_pvec (
    .orig_x(a_orig_x), .orig_y(a_orig_y), .orig_z(a_orig_z),
    .dir_x(a_dir_x), .dir_y(a_dir_y), .dir_z(a_dir_z),
    .v0_x(a_v0_x), .v0_y(a_v0_y), .v0_z(a_v0_z),
    .v1_x(a_v1_x), .v1_y(a_v1_y), .v1_z(a_v1_z),
    .v2_x(a_v2_x), .v2_y(a_v2_y), .v2_z(a_v2_z),
    .det(det_w), .u_num(u_num_w)
  );

  qvec_unit #(.COORD_W(COORD_W)) u_qvec (
    .orig_x(a_orig_x), .orig_y(a_orig_y), .orig_z(a_orig_z),
    .dir_x(a_dir_x), .dir_y(a_dir_y), .dir_z(a_dir_z),
    .v0_x(a_v0_x), .v0_y(a_v0_y), .v0_z(a_v0_z),
    .v1_x(a_v1_x), .v1_y(a_v1_y), .v1_z(a_v1_z),
    .v2_x(a_v2_x), .v2_y(a_v2_y), .v2_z(a_v2_z),
    .v_num(v_num_w), .t_num(t_num_w)
  );

  assign b_d = {a_tri_id, det_w, u_num_w, v_num_w, t_num_w};

  // The middle capture acknowledges latch A and hands a new result to latch C.
  stage_latch #(.WIDTH(B_W)) u_latch_mid (
    .clk(clk), .rst(rst), .done(in_capture), .next_capture(out_valid),
    .capture(mid_capture), .data_in(b_d), .data_out(b_q)
  );

  assign {b_tri_id, b_det, b_u_num, b_v_num, b_t_num} = b_q;

  hit_resolve #(.COORD_W(COORD_W)) u_resolve (
    .det(b_det), .u_num(b_u_num), .v_num(b_v_num), .t_num(b_t_num),
    .result(res_w), .det_abs(det_abs_w), .t_out(t_out_w)
  );

  assign c_d = {b_tri_id, res_w, det_abs_w, t_out_w};

  stage_latch #(.WIDTH(C_W)) u_latch_out (
    .clk(clk), .rst(rst), .done(mid_capture), .next_capture(out_taken),
    .capture(out_valid), .data_in(c_d), .data_out(c_q)
  );

  assign {out_tri_id, c_res, det, t_num} = c_q;
  assign result = isect_pkg::result_t'(c_res);

endmodule

`default_nettype wire

/* test/isect_props.sv */
`timescale 1ns/100ps
`default_nettype none

module isect_props #(
  parameter int WIDTH = 8
) (
  input logic                    clk,
  input logic                    rst,
  input logic                    capture,
  input isect_pkg::latch_state_t state,
  input logic [WIDTH-1:0]        data_out
);

  a_single_pulse: assert property (@(posedge clk) disable iff (rst) capture |=> !capture)
    else $error("capture stayed high for two cycles");

  // The load state drives capture, so the cycle before it must be some other state.
  a_after_other: assert property (@(posedge clk) disable iff (rst)
    capture |-> $past(state) != isect_pkg::load)
    else $error("capture came right after a load cycle");

  a_data_hold: assert property (@(posedge clk) disable iff (rst)
    !$stable(data_out) |-> state == isect_pkg::load)
    else $error("data_out changed without a load");

  a_reset_quiet: assert property (@(posedge clk) rst |-> !capture)
    else $error("capture high during reset");

endmodule

bind stage_latch isect_props #(.WIDTH(WIDTH)) u_props (
  .clk(clk), .rst(rst), .capture(capture), .state(state), .data_out(data_out)
);

`default_nettype wire

/* test/isect_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module isect_tb;

  localparam int COORD_W = 12;
  localparam int ID_W = 9;
  localparam int DOT_W = 3 * COORD_W + 4;
  localparam int N_TABLE = 12;
  localparam int N_RAND = 40;
  localparam int N_CASES = N_TABLE + N_RAND;
  localparam int WAIT_MAX = 40;
  localparam int WATCHDOG_NS = (N_CASES * 40 + 100) * 40;

  logic clk = 1'b0;
  logic rst;
  logic in_valid;
  logic in_capture;
  logic out_valid;
  logic out_taken;
  logic signed [COORD_W-1:0] crd [0:14]; // Origin, direction, v0, v1, v2, each as x y z.
  logic [ID_W-1:0] tri_id;
  logic [ID_W-1:0] out_tri_id;
  isect_pkg::result_t result;
  logic signed [DOT_W-1:0] t_num;
  logic signed [DOT_W-1:0] det;

  int tbl [0:N_TABLE-1][0:15]; // Fifteen coordinates, then the expected result code.
  int stim [0:N_CASES-1][0:14];
  logic [ID_W-1:0] ids [0:N_CASES-1];
  longint exp_det [0:N_CASES-1];
  longint exp_t [0:N_CASES-1];
  int exp_res [0:N_CASES-1];
  int delays [0:N_RAND-1];
  logic [31:0] rng;
  int errors;
  int err_mark;
  int passed;
  int failed;

  isect_top i_dut (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_capture(in_capture),
    .orig_x(crd[0]), .orig_y(crd[1]), .orig_z(crd[2]),
    .dir_x(crd[3]), .dir_y(crd[4]), .dir_z(crd[5]),
    .v0_x(crd[6]), .v0_y(crd[7]), .v0_z(crd[8]),
    .v1_x(crd[9]), .v1_y(crd[10]), .v1_z(crd[11]),
    .v2_x(crd[12]), .v2_y(crd[13]), .v2_z(crd[14]),
    .tri_id(tri_id), .out_valid(out_valid), .out_taken(out_taken), .result(result),
    .t_num(t_num), .det(det), .out_tri_id(out_tri_id)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Moller-Trumbore in 64 bits, signs normalized so that det is never negative.
  task automatic compute_expected(input int idx);
    longint d [0:2];
    longint e1 [0:2];
    longint e2 [0:2];
    longint tv [0:2];
    longint p [0:2];
    longint q [0:2];
    longint dt, u, v, t;
    int k;
    for (k = 0; k < 3; k++) begin
      d[k] = stim[idx][3 + k];
      e1[k] = stim[idx][9 + k] - stim[idx][6 + k];
      e2[k] = stim[idx][12 + k] - stim[idx][6 + k];
      tv[k] = stim[idx][k] - stim[idx][6 + k];
    end
    p[0] = d[1] * e2[2] - d[2] * e2[1];
    p[1] = d[2] * e2[0] - d[0] * e2[2];
    p[2] = d[0] * e2[1] - d[1] * e2[0];
    q[0] = tv[1] * e1[2] - tv[2] * e1[1];
    q[1] = tv[2] * e1[0] - tv[0] * e1[2];
    q[2] = tv[0] * e1[1] - tv[1] * e1[0];
    dt = e1[0] * p[0] + e1[1] * p[1] + e1[2] * p[2];
    u = tv[0] * p[0] + tv[1] * p[1] + tv[2] * p[2];
    v = d[0] * q[0] + d[1] * q[1] + d[2] * q[2];
    t = e2[0] * q[0] + e2[1] * q[1] + e2[2] * q[2];
    if (dt < 0) begin
      dt = -dt;
      u = -u;
      v = -v;
      t = -t;
    end
    if (dt == 0) exp_res[idx] = 0;
    else if (u < 0 || v < 0 || u + v > dt) exp_res[idx] = 1;
    else if (t <= 0) exp_res[idx] = 2;
    else exp_res[idx] = 3;
    exp_det[idx] = dt;
    exp_t[idx] = t;
  endtask

  task automatic check_value(input string name, input longint actual, input longint expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
      errors++;
    end
  endtask

  task automatic check_result(input int idx);
    check_value("result", result, exp_res[idx]);
    check_value("det", det, exp_det[idx]);
    check_value("t_num", t_num, exp_t[idx]);
    check_value("out_tri_id", out_tri_id, ids[idx]);
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: failed", name);
    end
    err_mark = errors;
  endtask

  task automatic start_request(input int idx);
    int i;
    @(negedge clk);
    for (i = 0; i < 15; i++) crd[i] = stim[idx][i];
    tri_id = ids[idx];
    in_valid = 1'b1;
  endtask

  // Counts falling edges until in_capture; in_valid drops after one cycle.
  task automatic wait_capture(input int idx, output int lat);
    int n;
    n = 0;
    lat = -1;
    while (lat < 0 && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
      in_valid = 1'b0;
      if (in_capture) lat = n;
    end
    if (lat < 0) begin
      $display("ERROR: request %0d was never captured", idx);
      errors++;
    end
  endtask

  task automatic send_request(input int idx, output int lat);
    start_request(idx);
    wait_capture(idx, lat);
  endtask

  task automatic wait_result(input int idx, output int lat);
    int n;
    n = 0;
    lat = out_valid ? 0 : -1;
    while (lat < 0 && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
      if (out_valid) lat = n;
    end
    if (lat < 0) begin
      $display("ERROR: no result came out for request %0d", idx);
      errors++;
    end else begin
      check_result(idx);
    end
  endtask

  task automatic pulse_taken();
    @(negedge clk);
    out_taken = 1'b1;
    @(negedge clk);
    out_taken = 1'b0;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: run timed out after %0d ns", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    int k;
    int j;
    int lat_c;
    int lat_r;
    int bp [0:3];
    logic seen;
    errors = 0;
    err_mark = 0;
    passed = 0;
    failed = 0;
    rst = 1'b1;
    in_valid = 1'b0;
    out_taken = 1'b0;
    tri_id = '0;
    for (k = 0; k < 15; k++) crd[k] = '0;
    // Triangle (0,0,0) (8,0,0) (0,8,0) unless noted.
    tbl[0]  = '{2, 2, 10, 0, 0, -1, 0, 0, 0, 8, 0, 0, 0, 8, 0, 3};
    tbl[1]  = '{2, 2, -10, 0, 0, 1, 0, 0, 0, 8, 0, 0, 0, 8, 0, 3}; // Back-facing.
    tbl[2]  = '{2, 2, 10, 1, 0, 0, 0, 0, 0, 8, 0, 0, 0, 8, 0, 0};
    tbl[3]  = '{-2, 2, 10, 0, 0, -1, 0, 0, 0, 8, 0, 0, 0, 8, 0, 1};
    tbl[4]  = '{2, -2, 10, 0, 0, -1, 0, 0, 0, 8, 0, 0, 0, 8, 0, 1};
    tbl[5]  = '{6, 6, 10, 0, 0, -1, 0, 0, 0, 8, 0, 0, 0, 8, 0, 1};
    tbl[6]  = '{2, 2, -10, 0, 0, -1, 0, 0, 0, 8, 0, 0, 0, 8, 0, 2};
    tbl[7]  = '{2, 2, 0, 0, 0, -1, 0, 0, 0, 8, 0, 0, 0, 8, 0, 2};
    tbl[8]  = '{1, 1, 10, 0, 0, -1, 0, 0, 0, 4, 4, 0, 8, 8, 0, 0}; // Degenerate.
    tbl[9]  = '{4, 4, 10, 0, 0, -1, 0, 0, 0, 8, 0, 0, 0, 8, 0, 3};
    tbl[10] = '{100, -50, 300, -3, 2, -20, -200, -200, 0, 300, -200, 10, 0, 400, -10, 3};
    tbl[11] = '{6, 6, -10, 0, 0, 1, 0, 0, 0, 8, 0, 0, 0, 8, 0, 1};
    rng = 32'he991;
    for (k = 0; k < N_CASES; k++) begin
      for (j = 0; j < 15; j++) begin
        rng = xorshift(rng);
        stim[k][j] = (k < N_TABLE) ? tbl[k][j] : int'(rng & 32'h7ff) - 1024;
      end
      rng = xorshift(rng);
      ids[k] = (k < N_TABLE) ? ID_W'(9'h100 + k) : rng[ID_W-1:0];
      if (k >= N_TABLE) delays[k - N_TABLE] = 1 + int'(rng[12:11]);
      compute_expected(k);
      if (k < N_TABLE) exp_res[k] = tbl[k][15];
    end

    repeat (16) @(negedge clk);
    rst = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_value("in_capture", in_capture, 0);
      check_value("out_valid", out_valid, 0);
    end
    check_value("result", result, 0);
    check_value("det", det, 0);
    check_value("t_num", t_num, 0);
    check_value("out_tri_id", out_tri_id, 0);
    end_test("reset");

    for (k = 0; k < N_TABLE; k++) begin
      send_request(k, lat_c);
      wait_result(k, lat_r);
      check_value("in_capture latency", lat_c, 1);
      check_value("out_valid latency", lat_c + lat_r, 3);
      pulse_taken();
      end_test($sformatf("table %0d", k));
    end

    // Three requests fill the pipe while out_taken is held low.
    bp = '{10, 2, 5, 7};
    for (k = 0; k < 3; k++) send_request(bp[k], lat_c);
    start_request(bp[3]);
    seen = 1'b0;
    repeat (12) begin
      @(negedge clk);
      in_valid = 1'b0;
      if (in_capture) seen = 1'b1;
    end
    if (seen) begin
      $display("ERROR: a fourth request was captured while the pipeline was full");
      errors++;
    end
    check_result(bp[0]);
    for (k = 1; k < 4; k++) begin
      pulse_taken();
      wait_result(bp[k], lat_r);
      if (k == 1) wait_capture(bp[3], lat_c);
    end
    pulse_taken();
    end_test("back-pressure");

    fork
      begin
        for (k = 0; k < N_RAND; k++) send_request(N_TABLE + k, lat_c);
      end
      begin
        for (j = 0; j < N_RAND; j++) begin
          wait_result(N_TABLE + j, lat_r);
          end_test($sformatf("random %0d", j));
          repeat (delays[j] - 1) @(negedge clk);
          pulse_taken();
        end
      end
    join

    $display("Tests passed: %0d, failed: %0d, check errors: %0d", passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
common/isect_pkg.sv
verilog/stage_latch.sv
verilog/pvec_unit.sv
verilog/qvec_unit.sv
verilog/hit_resolve.sv
verilog/isect_top.sv
test/isect_props.sv
test/isect_tb.sv
